// ==== verilog/bpu_pkg.sv ====
package bpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] addr_t;

    // bimodal direction table
    localparam int BIM_ENTRIES = 512;
    localparam int BIM_IDX_W   = 9;   // pc[9:1]

    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_WEAK_NT = 2'b01;

    // branch target buffer, direct mapped
    localparam int BTB_ENTRIES = 256;
    localparam int BTB_IDX_W   = 8;   // pc[9:2]
    localparam int BTB_TAG_W   = 22;  // pc[31:10]

    // return address stack
    localparam int RAS_DEPTH = 32;
    localparam int RAS_PTR_W = 6;     // count 0..32

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

    // one instruction word, seen through the formats the predictor needs
    typedef union packed {
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
    } inst_t;

endpackage

// ==== verilog/bpu_inst_decode.sv ====
`timescale 1ns/1ps

module bpu_inst_decode (
    input  bpu_pkg::inst_t inst_i,
    output logic           is_branch_o,
    output logic           is_jal_o,
    output logic           is_jalr_o,
    output logic           is_ret_o,
    output bpu_pkg::addr_t b_off_o,
    output bpu_pkg::addr_t j_off_o
);

    logic rs1_is_link;
    logic rd_is_zero;
    logic imm_is_zero;

    assign is_branch_o = (inst_i.b_fmt.opcode == bpu_pkg::OP_BRANCH);
    assign is_jal_o    = (inst_i.j_fmt.opcode == bpu_pkg::OP_JAL);
    assign is_jalr_o   = (inst_i.i_fmt.opcode == bpu_pkg::OP_JALR);

    // return is jalr x0, 0(ra) or jalr x0, 0(t0)
    assign rs1_is_link = (inst_i.i_fmt.rs1 == bpu_pkg::REG_RA) ||
                         (inst_i.i_fmt.rs1 == bpu_pkg::REG_T0);
    assign rd_is_zero  = (inst_i.i_fmt.rd == 5'd0);
    assign imm_is_zero = (inst_i.i_fmt.imm == 12'd0);

    assign is_ret_o = is_jalr_o && rd_is_zero && rs1_is_link && imm_is_zero;

    // b-type offset, 13 bits sign extended
    assign b_off_o = {{19{inst_i.b_fmt.imm_12}},
                      inst_i.b_fmt.imm_12,
                      inst_i.b_fmt.imm_11,
                      inst_i.b_fmt.imm_10_5,
                      inst_i.b_fmt.imm_4_1,
                      1'b0};

    // j-type offset, 21 bits sign extended
    assign j_off_o = {{11{inst_i.j_fmt.imm_20}},
                      inst_i.j_fmt.imm_20,
                      inst_i.j_fmt.imm_19_12,
                      inst_i.j_fmt.imm_11,
                      inst_i.j_fmt.imm_10_1,
                      1'b0};

endmodule

// ==== verilog/bpu_bimodal.sv ====
`timescale 1ns/1ps

module bpu_bimodal (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t rd_pc_i,
    input  bpu_pkg::addr_t wr_pc_i,
    input  logic           train_i,
    input  logic           taken_i,
    output bpu_pkg::ctr_t  rd_ctr_o
);

    bpu_pkg::ctr_t ctr_q [bpu_pkg::BIM_ENTRIES];

    logic [bpu_pkg::BIM_IDX_W-1:0] rd_idx;
    logic [bpu_pkg::BIM_IDX_W-1:0] wr_idx;

    // halfword granular index
    assign rd_idx = rd_pc_i[bpu_pkg::BIM_IDX_W:1];
    assign wr_idx = wr_pc_i[bpu_pkg::BIM_IDX_W:1];

    assign rd_ctr_o = ctr_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bpu_pkg::BIM_ENTRIES; i++) begin
                ctr_q[i] <= bpu_pkg::CTR_WEAK_NT;
            end
        end else if (train_i) begin
            if (taken_i) begin
                if (ctr_q[wr_idx] != 2'b11)
                    ctr_q[wr_idx] <= ctr_q[wr_idx] + 2'd1;  // saturate at strong taken
            end else begin
                if (ctr_q[wr_idx] != 2'b00)
                    ctr_q[wr_idx] <= ctr_q[wr_idx] - 2'd1;
            end
        end
    end

endmodule

// ==== verilog/bpu_btb.sv ====
`timescale 1ns/1ps

module bpu_btb (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t rd_pc_i,
    input  logic           wr_i,
    input  bpu_pkg::addr_t wr_pc_i,
    input  bpu_pkg::addr_t wr_target_i,
    output logic           hit_o,
    output bpu_pkg::addr_t target_o
);

    logic [bpu_pkg::BTB_TAG_W-1:0] tag_q    [bpu_pkg::BTB_ENTRIES];
    bpu_pkg::addr_t                target_q [bpu_pkg::BTB_ENTRIES];
    logic [bpu_pkg::BTB_ENTRIES-1:0] valid_q;

    logic [bpu_pkg::BTB_IDX_W-1:0] rd_idx;
    logic [bpu_pkg::BTB_IDX_W-1:0] wr_idx;
    logic [bpu_pkg::BTB_TAG_W-1:0] rd_tag;
    logic [bpu_pkg::BTB_TAG_W-1:0] wr_tag;

    // word index, tag is everything above it
    assign rd_idx = rd_pc_i[bpu_pkg::BTB_IDX_W+1:2];
    assign wr_idx = wr_pc_i[bpu_pkg::BTB_IDX_W+1:2];
    assign rd_tag = rd_pc_i[bpu_pkg::XLEN-1 -: bpu_pkg::BTB_TAG_W];
    assign wr_tag = wr_pc_i[bpu_pkg::XLEN-1 -: bpu_pkg::BTB_TAG_W];

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target payload
    always_ff @(posedge clk) begin
        if (wr_i) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_target_i;
        end
    end

endmodule

// ==== verilog/bpu_ras.sv ====
`timescale 1ns/1ps

module bpu_ras (
    input  logic           clk,
    input  logic           rst,
    input  logic           push_i,
    input  bpu_pkg::addr_t push_addr_i,
    input  logic           pop_i,
    output bpu_pkg::addr_t top_o,
    output logic           empty_o
);

    localparam int SLOT_W = bpu_pkg::RAS_PTR_W - 1;

    bpu_pkg::addr_t stack_q [bpu_pkg::RAS_DEPTH];

    logic [bpu_pkg::RAS_PTR_W-1:0] sp_q;       // number of live entries
    logic [bpu_pkg::RAS_PTR_W-1:0] sp_popped;
    logic [SLOT_W-1:0]             top_idx;
    logic                          pop_ok;
    logic                          push_ok;

    // wraps to the last slot when full, which is the right top
    assign top_idx = sp_q[SLOT_W-1:0] - 1'b1;
    assign top_o   = stack_q[top_idx];
    assign empty_o = (sp_q == '0);

    // pop first, then push into the freed slot
    assign pop_ok    = pop_i && !empty_o;
    assign sp_popped = sp_q - {{(bpu_pkg::RAS_PTR_W-1){1'b0}}, pop_ok};
    assign push_ok   = push_i &&
                       (sp_popped != bpu_pkg::RAS_PTR_W'(bpu_pkg::RAS_DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else begin
            sp_q <= sp_popped + {{(bpu_pkg::RAS_PTR_W-1){1'b0}}, push_ok};
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            stack_q[sp_popped[SLOT_W-1:0]] <= push_addr_i;
        end
    end

endmodule

// ==== verilog/bpu_control.sv ====
`timescale 1ns/1ps

module bpu_control (
    input  bpu_pkg::addr_t if_pc_i,
    input  logic           if_is_branch_i,
    input  logic           if_is_jal_i,
    input  logic           if_is_jalr_i,
    input  logic           if_is_ret_i,
    input  bpu_pkg::addr_t if_b_off_i,
    input  bpu_pkg::addr_t if_j_off_i,
    input  bpu_pkg::ctr_t  bim_ctr_i,
    input  logic           btb_hit_i,
    input  bpu_pkg::addr_t btb_target_i,
    input  bpu_pkg::addr_t ras_top_i,
    input  logic           ras_empty_i,
    input  logic           ex_valid_i,
    input  logic           ex_taken_i,
    input  logic           ex_is_ret_i,
    output logic           is_cf_o,
    output logic           pred_taken_o,
    output bpu_pkg::addr_t pred_target_o,
    output logic           train_o,
    output logic           btb_wr_o,
    output logic           ras_pop_o
);

    bpu_pkg::addr_t pc_plus4;

    assign pc_plus4 = if_pc_i + bpu_pkg::XLEN'(4);
    assign is_cf_o  = if_is_branch_i || if_is_jal_i || if_is_jalr_i;

    always_comb begin
        pred_taken_o  = 1'b0;
        pred_target_o = pc_plus4;
        if (if_is_ret_i) begin
            if (!ras_empty_i) begin
                pred_taken_o  = 1'b1;
                pred_target_o = ras_top_i;
            end
        end else if (if_is_jal_i) begin
            pred_taken_o  = 1'b1;
            pred_target_o = btb_hit_i ? btb_target_i : if_pc_i + if_j_off_i;
        end else if (is_cf_o) begin
            pred_taken_o = bim_ctr_i[1];  // counter msb is the direction
            if (pred_taken_o) begin
                if (btb_hit_i)
                    pred_target_o = btb_target_i;
                else if (if_is_branch_i)
                    pred_target_o = if_pc_i + if_b_off_i;
                // indirect jump without a btb entry stays at pc+4
            end
        end
    end

    // execute feedback strobes
    assign train_o   = ex_valid_i;
    assign btb_wr_o  = ex_valid_i && ex_taken_i;
    assign ras_pop_o = ex_valid_i && ex_taken_i && ex_is_ret_i;

endmodule

// ==== verilog/bpu_top.sv ====
`timescale 1ns/1ps

module bpu_top (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t if_pc_i,
    input  bpu_pkg::inst_t if_inst_i,
    input  logic           ex_valid_i,
    input  logic           ex_taken_i,
    input  bpu_pkg::addr_t ex_pc_i,
    input  bpu_pkg::addr_t ex_target_i,
    input  bpu_pkg::inst_t ex_inst_i,
    input  logic           id_push_i,
    input  bpu_pkg::addr_t id_push_addr_i,
    output logic           is_cf_o,
    output logic           pred_taken_o,
    output bpu_pkg::addr_t pred_target_o
);

    logic           if_is_branch, if_is_jal, if_is_jalr, if_is_ret;
    bpu_pkg::addr_t if_b_off, if_j_off;
    logic           ex_is_ret;
    bpu_pkg::ctr_t  bim_ctr;
    logic           btb_hit, ras_empty;
    bpu_pkg::addr_t btb_target, ras_top;
    logic           train, btb_wr, ras_pop;

    bpu_inst_decode u_if_dec (
        .inst_i(if_inst_i), .is_branch_o(if_is_branch), .is_jal_o(if_is_jal),
        .is_jalr_o(if_is_jalr), .is_ret_o(if_is_ret), .b_off_o(if_b_off),
        .j_off_o(if_j_off));

    // execute side only needs the return flag
    bpu_inst_decode u_ex_dec (
        .inst_i(ex_inst_i), .is_branch_o(), .is_jal_o(), .is_jalr_o(),
        .is_ret_o(ex_is_ret), .b_off_o(), .j_off_o());

    bpu_bimodal u_bim (
        .clk(clk), .rst(rst), .rd_pc_i(if_pc_i), .wr_pc_i(ex_pc_i),
        .train_i(train), .taken_i(ex_taken_i), .rd_ctr_o(bim_ctr));

    bpu_btb u_btb (
        .clk(clk), .rst(rst), .rd_pc_i(if_pc_i), .wr_i(btb_wr), .wr_pc_i(ex_pc_i),
        .wr_target_i(ex_target_i), .hit_o(btb_hit), .target_o(btb_target));

    bpu_ras u_ras (
        .clk(clk), .rst(rst), .push_i(id_push_i), .push_addr_i(id_push_addr_i),
        .pop_i(ras_pop), .top_o(ras_top), .empty_o(ras_empty));

    bpu_control u_ctrl (
        .if_pc_i(if_pc_i), .if_is_branch_i(if_is_branch), .if_is_jal_i(if_is_jal),
        .if_is_jalr_i(if_is_jalr), .if_is_ret_i(if_is_ret), .if_b_off_i(if_b_off),
        .if_j_off_i(if_j_off), .bim_ctr_i(bim_ctr), .btb_hit_i(btb_hit),
        .btb_target_i(btb_target), .ras_top_i(ras_top), .ras_empty_i(ras_empty),
        .ex_valid_i(ex_valid_i), .ex_taken_i(ex_taken_i), .ex_is_ret_i(ex_is_ret),
        .is_cf_o(is_cf_o), .pred_taken_o(pred_taken_o), .pred_target_o(pred_target_o),
        .train_o(train), .btb_wr_o(btb_wr), .ras_pop_o(ras_pop));

endmodule

// ==== verification/bpu_asserts.sv ====
`timescale 1ns/1ps

module bpu_asserts (
    input logic           clk,
    input logic           rst,
    input logic           is_cf_i,
    input logic           pred_taken_i,
    input bpu_pkg::addr_t pred_target_i,
    input bpu_pkg::addr_t if_pc_i,
    input logic [bpu_pkg::RAS_PTR_W-1:0] sp_i
);

    taken_is_cf: assert property (@(posedge clk) disable iff (rst) pred_taken_i |-> is_cf_i)
        else $error("taken prediction on a word that is not control flow");

    // fall through address for anything predicted not taken
    not_taken_target: assert property (@(posedge clk) disable iff (rst)
        !pred_taken_i |-> pred_target_i == if_pc_i + 32'd4)
        else $error("not taken prediction with a target other than pc+4");

    sp_in_range: assert property (@(posedge clk) disable iff (rst)
        sp_i <= bpu_pkg::RAS_PTR_W'(bpu_pkg::RAS_DEPTH))
        else $error("return stack pointer beyond stack depth");

endmodule

bind bpu_top bpu_asserts u_asserts (
    .clk(clk), .rst(rst), .is_cf_i(is_cf_o), .pred_taken_i(pred_taken_o),
    .pred_target_i(pred_target_o), .if_pc_i(if_pc_i), .sp_i(u_ras.sp_q));

// ==== verification/bpu_tb.sv ====
`timescale 1ns/1ps

module bpu_tb;

    localparam int RAND_CYCLES     = 200;
    localparam int DIRECTED_CYCLES = 150;  // upper bound for the directed part
    localparam int TEST_CYCLES     = RAND_CYCLES + DIRECTED_CYCLES + 4;

    logic clk = 1'b0;
    logic rst, ex_valid, ex_taken, id_push, is_cf, pred_taken, checking;
    bpu_pkg::addr_t if_pc, ex_pc, ex_target, id_push_addr, pred_target;
    bpu_pkg::inst_t if_inst, ex_inst;

    bpu_pkg::ctr_t  m_ctr [bpu_pkg::BIM_ENTRIES];
    logic [21:0]    m_tag [bpu_pkg::BTB_ENTRIES];
    bpu_pkg::addr_t m_tgt [bpu_pkg::BTB_ENTRIES];
    logic           m_vld [bpu_pkg::BTB_ENTRIES];
    bpu_pkg::addr_t m_stack [bpu_pkg::RAS_DEPTH];
    int             m_sp, errors;
    logic [31:0]    seed = 32'h7024_f6f1;

    bpu_top u_dut (
        .clk(clk), .rst(rst), .if_pc_i(if_pc), .if_inst_i(if_inst), .ex_valid_i(ex_valid),
        .ex_taken_i(ex_taken), .ex_pc_i(ex_pc), .ex_target_i(ex_target),
        .ex_inst_i(ex_inst), .id_push_i(id_push), .id_push_addr_i(id_push_addr),
        .is_cf_o(is_cf), .pred_taken_o(pred_taken), .pred_target_o(pred_target));

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd3, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    localparam logic [31:0] RET  = {12'd0, 5'd1, 3'd0, 5'd0, 7'b1100111};  // jalr x0, 0(ra)
    localparam logic [31:0] JALR = {12'd8, 5'd6, 3'd0, 5'd1, 7'b1100111};
    localparam logic [31:0] NOP  = 32'h0000_0013;

    function automatic logic is_return(input logic [31:0] i);
        return i[6:0] == 7'b1100111 && i[11:7] == 5'd0 && i[31:20] == 12'd0 &&
               (i[19:15] == 5'd1 || i[19:15] == 5'd5);
    endfunction

    // reference prediction built from the instruction bits
    function automatic void predict(input logic [31:0] pc, input logic [31:0] i,
                                    output logic cf, output logic tk, output logic [31:0] tgt);
        logic [31:0] b_off, j_off;
        logic        hit;
        b_off = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
        j_off = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
        hit   = m_vld[pc[9:2]] && m_tag[pc[9:2]] == pc[31:10];
        cf    = i[6:0] inside {7'b1100011, 7'b1101111, 7'b1100111};
        tk    = 1'b0;
        tgt   = pc + 32'd4;
        if (is_return(i)) begin
            if (m_sp > 0) begin
                tk  = 1'b1;
                tgt = m_stack[m_sp-1];
            end
        end else if (i[6:0] == 7'b1101111) begin
            tk  = 1'b1;
            tgt = hit ? m_tgt[pc[9:2]] : pc + j_off;
        end else if (cf && m_ctr[pc[9:1]][1]) begin
            tk = 1'b1;
            if (hit) tgt = m_tgt[pc[9:2]];
            else if (i[6:0] == 7'b1100011) tgt = pc + b_off;
        end
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h got %h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input bpu_pkg::addr_t exp,
                              input bpu_pkg::addr_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h got %h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic update_model();
        if (ex_valid) begin
            if (ex_taken && m_ctr[ex_pc[9:1]] != 2'b11) m_ctr[ex_pc[9:1]]++;
            if (!ex_taken && m_ctr[ex_pc[9:1]] != 2'b00) m_ctr[ex_pc[9:1]]--;
            if (ex_taken) begin
                m_vld[ex_pc[9:2]] = 1'b1;
                m_tag[ex_pc[9:2]] = ex_pc[31:10];
                m_tgt[ex_pc[9:2]] = ex_target;
                if (is_return(ex_inst) && m_sp > 0) m_sp--;  // pop before push
            end
        end
        if (id_push && m_sp < bpu_pkg::RAS_DEPTH) begin
            m_stack[m_sp] = id_push_addr;
            m_sp++;
        end
    endtask

    // compare just before the rising edge, then advance the model
    always begin : compare
        logic        e_cf, e_tk;
        logic [31:0] e_tgt;
        @(negedge clk);
        #1.5;
        if (checking) begin
            predict(if_pc, if_inst, e_cf, e_tk, e_tgt);
            check_bit("is_cf_o", e_cf, is_cf);
            check_bit("pred_taken_o", e_tk, pred_taken);
            check_addr("pred_target_o", e_tgt, pred_target);
            update_model();
        end
    end

    task automatic drive(input logic [31:0] pc, input logic [31:0] inst, input logic exv,
                         input logic ext, input logic [31:0] expc, input logic [31:0] extgt,
                         input logic [31:0] exinst, input logic push, input logic [31:0] pa);
        @(negedge clk);
        if_pc        = pc;
        if_inst      = inst;
        ex_valid     = exv;
        ex_taken     = ext;
        ex_pc        = expc;
        ex_target    = extgt;
        ex_inst      = exinst;
        id_push      = push;
        id_push_addr = pa;
    endtask

    function automatic logic [31:0] pool_pc(input logic [31:0] r);
        return 32'h0001_0000 | {19'd0, r[10], 6'd0, r[3:0], 2'b00};  // shared indices
    endfunction

    function automatic logic [31:0] pick_inst(input logic [31:0] r);
        case (r[7:5])
            3'd0, 3'd1: return enc_branch({r[20:13], 5'd0} - 13'h40);
            3'd2:       return enc_jal({r[24:13], 9'd0});
            3'd3:       return JALR;
            3'd4:       return RET;
            default:    return NOP;
        endcase
    endfunction

    initial begin : watchdog
        #(TEST_CYCLES * 4 * 2);
        $display("timeout: stimulus did not complete within %0d cycles", TEST_CYCLES * 2);
        $display("Finished with errors");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r, q;
        errors   = 0;
        checking = 1'b0;
        m_sp     = 0;
        foreach (m_ctr[i]) m_ctr[i] = bpu_pkg::CTR_WEAK_NT;
        foreach (m_vld[i]) m_vld[i] = 1'b0;
        rst = 1'b1;
        {ex_valid, ex_taken, id_push} = '0;
        {if_pc, ex_pc, ex_target, id_push_addr} = '0;
        if_inst = NOP;
        ex_inst = NOP;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst      = 1'b0;
        checking = 1'b1;
        // plain words, then jal before and after a taken report
        for (int i = 0; i < 4; i++) drive(32'h400 + i * 4, NOP, 0, 0, 0, 0, NOP, 0, 0);
        drive(32'h1000, enc_jal(21'h40), 1, 1, 32'h1000, 32'h2222_0000, enc_jal(21'h40), 0, 0);
        drive(32'h1000, enc_jal(21'h40), 0, 0, 0, 0, NOP, 0, 0);
        // branch training up, tag conflict, then training down
        drive(32'h1104, enc_branch(13'h80), 1, 1, 32'h1104, 32'h1184, NOP, 0, 0);
        drive(32'h1104, enc_branch(13'h80), 1, 1, 32'h1104, 32'h1184, NOP, 0, 0);
        drive(32'h1504, enc_branch(13'h1f0), 0, 0, 0, 0, NOP, 0, 0);
        for (int i = 0; i < 3; i++)
            drive(32'h1104, enc_branch(13'h80), 1, 0, 32'h1104, 0, NOP, 0, 0);
        drive(32'h1104, enc_branch(13'h80), 0, 0, 0, 0, NOP, 0, 0);
        // returns pop pushed addresses in lifo order
        for (int i = 0; i < 3; i++) drive(32'h2000, NOP, 0, 0, 0, 0, NOP, 1, 32'h3000 + i * 16);
        for (int i = 0; i < 4; i++) drive(32'h2100, RET, 1, 1, 32'h2100, 0, RET, 0, 0);
        // overfill, replace the top, then drain
        for (int i = 0; i < 33; i++)
            drive(32'h2000, NOP, 0, 0, 0, 0, NOP, 1, 32'h8000_0000 + i * 4);
        drive(32'h2100, RET, 1, 1, 32'h2100, 0, RET, 1, 32'hcafe_0000);
        for (int i = 0; i < 33; i++) drive(32'h2100, RET, 1, 1, 32'h2100, 0, RET, 0, 0);
        for (int i = 0; i < RAND_CYCLES; i++) begin
            r = lcg_next();
            q = lcg_next();
            drive(pool_pc(r), pick_inst(r), q[0], q[1], pool_pc(q),
                  {q[31:12], 12'd0}, pick_inst(q), q[3:2] == 2'b00, {r[31:16], 16'd0});
        end
        @(posedge clk);
        checking = 1'b0;
        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== bpu.f ====
verilog/bpu_pkg.sv
verilog/bpu_inst_decode.sv
verilog/bpu_bimodal.sv
verilog/bpu_btb.sv
verilog/bpu_ras.sv
verilog/bpu_control.sv
verilog/bpu_top.sv
verification/bpu_asserts.sv
verification/bpu_tb.sv

// ==== Makefile ====
SIM = obj_dir/bpu_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -f bpu.f --top-module bpu_tb -o bpu_sim
	$(SIM) | tee /dev/stderr | grep -F "Finished with no errors" > /dev/null

clean:
	rm -rf obj_dir
